/* design/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

`define MEM_ADDR_WIDTH  32  // Byte address.
`define MEM_DATA_WIDTH  32
`define MEM_WORDS       256 // Word index is addr[9:2].

`define MEM_DELAY       5   // Accept edge to ack edge.

// Entries per client queue.
`define MEM_QUEUE_DEPTH 2

`endif

/* design/mem_pkg.sv */
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

    // One memory access as issued by a client.
    typedef struct packed {
        logic                       write;  // Store when set.
        logic [`MEM_ADDR_WIDTH-1:0] addr;   // Low two bits ignored.
        logic [`MEM_DATA_WIDTH-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                       was_write;
        logic [`MEM_DATA_WIDTH-1:0] data;   // Zero for writes.
    } mem_rsp_t;

    typedef enum logic {
        CLIENT_FETCH = 1'b0,
        CLIENT_LSU   = 1'b1
    } client_id_t;

endpackage

`default_nettype wire

/* design/client_port.sv */
`timescale 1ns/1ns
`default_nettype none

module client_port (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire logic               req_valid,
    input  wire mem_pkg::mem_req_t  req,
    output logic                    req_ready,

    output logic                    head_valid,
    output mem_pkg::mem_req_t       head,
    input  wire logic               pop
);
    import mem_pkg::*;

    localparam int PTR_W = (`MEM_QUEUE_DEPTH > 1) ? $clog2(`MEM_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`MEM_QUEUE_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`MEM_QUEUE_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`MEM_QUEUE_DEPTH - 1);

    mem_req_t         entries [`MEM_QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] used;     // Occupancy.

    logic             push;
    logic             take;

    assign req_ready  = (used != FULL);
    assign head_valid = (used != '0);
    assign head       = entries[rd_ptr];

    assign push = req_valid && req_ready;
    assign take = pop && head_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            used   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged.
            case ({push, take})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= req;
        end
    end

endmodule

`default_nettype wire

/* design/mem_delayed.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_delayed (
    input  wire logic                           clk,
    input  wire logic                           rst,

    input  wire logic                           issue,
    input  wire mem_pkg::mem_req_t              issue_req,

    output logic                                busy,
    output logic                                ack,
    output logic [`MEM_DATA_WIDTH-1:0]          rd_data,

    input  wire logic                           oob_wen,
    input  wire logic [$clog2(`MEM_WORDS)-1:0]  oob_wr_addr,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     oob_wr_data
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_DELAY + 1);
    localparam logic [CNT_W-1:0] COUNT_START = CNT_W'(`MEM_DELAY - 1);

    logic [`MEM_DATA_WIDTH-1:0] mem [`MEM_WORDS];

    mem_req_t         req_q;    // Request being served.
    logic             pending;
    logic [CNT_W-1:0] count;

    logic             n_pending;
    logic [CNT_W-1:0] n_count;
    logic             n_busy;
    logic             n_ack;

    logic             accept;
    logic             finish;
    logic [IDX_W-1:0] idx;

    // Word index wraps modulo the memory size.
    assign idx    = req_q.addr[IDX_W+1:2];
    assign accept = issue && !pending;
    assign finish = pending && (count == '0);

    always_comb begin
        n_pending = pending;
        n_count   = count;
        n_busy    = 1'b0;
        n_ack     = 1'b0;

        if (finish) begin
            n_pending = 1'b0;   // Access happens on this edge.
            n_ack     = 1'b1;
        end else if (pending) begin
            n_count = count - 1'b1;
            n_busy  = 1'b1;
        end else if (accept) begin
            n_pending = 1'b1;
            n_count   = COUNT_START;
            n_busy    = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            count   <= '0;
            busy    <= 1'b0;
            ack     <= 1'b0;
            rd_data <= '0;
        end else begin
            pending <= n_pending;
            count   <= n_count;
            busy    <= n_busy;
            ack     <= n_ack;
            // Read word only shows in the ack cycle.
            if (finish && !req_q.write) begin
                rd_data <= mem[idx];
            end else begin
                rd_data <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= issue_req;
        end
    end

    // Out-of-band loading only while reset is held.
    always_ff @(posedge clk) begin
        if (rst) begin
            if (oob_wen) begin
                mem[oob_wr_addr] <= oob_wr_data;
            end
        end else if (finish && req_q.write) begin
            mem[idx] <= req_q.data;
        end
    end

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  wire logic                       clk,
    input  wire logic                       rst,

    input  wire logic                       fetch_head_valid,
    input  wire mem_pkg::mem_req_t          fetch_head,
    output logic                            fetch_pop,

    input  wire logic                       lsu_head_valid,
    input  wire mem_pkg::mem_req_t          lsu_head,
    output logic                            lsu_pop,

    output logic                            issue,
    output mem_pkg::mem_req_t               issue_req,
    input  wire logic                       busy,
    input  wire logic                       ack,
    input  wire logic [`MEM_DATA_WIDTH-1:0] rd_data,

    output logic                            fetch_rsp_valid,
    output logic                            lsu_rsp_valid,
    output mem_pkg::mem_rsp_t               rsp
);
    import mem_pkg::*;

    client_id_t priority_q;     // Wins when both heads are valid.
    client_id_t grant;
    client_id_t owner_q;
    logic       was_write_q;
    logic       issued_q;
    logic       can_issue;

    // The memory needs a cycle to raise busy after it accepts.
    assign can_issue = !busy && !ack && !issued_q;

    always_comb begin
        grant = priority_q;
        if (fetch_head_valid && !lsu_head_valid) begin
            grant = CLIENT_FETCH;
        end else if (lsu_head_valid && !fetch_head_valid) begin
            grant = CLIENT_LSU;
        end
    end

    assign issue     = can_issue && (fetch_head_valid || lsu_head_valid);
    assign issue_req = (grant == CLIENT_FETCH) ? fetch_head : lsu_head;
    assign fetch_pop = issue && (grant == CLIENT_FETCH);
    assign lsu_pop   = issue && (grant == CLIENT_LSU);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            priority_q <= CLIENT_FETCH;
            issued_q   <= 1'b0;
        end else begin
            issued_q <= issue;
            if (issue) begin
                // Other client goes first next time.
                priority_q <= (grant == CLIENT_FETCH) ? CLIENT_LSU : CLIENT_FETCH;
            end
        end
    end

    // Only one access is outstanding, so one owner record is enough.
    always_ff @(posedge clk) begin
        if (issue) begin
            owner_q     <= grant;
            was_write_q <= issue_req.write;
        end
    end

    assign fetch_rsp_valid = ack && (owner_q == CLIENT_FETCH);
    assign lsu_rsp_valid   = ack && (owner_q == CLIENT_LSU);

    assign rsp = '{was_write: was_write_q, data: rd_data};

endmodule

`default_nettype wire

/* design/mem_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem (
    input  wire logic                           clk,
    input  wire logic                           rst,

    input  wire logic                           fetch_req_valid,
    input  wire mem_pkg::mem_req_t              fetch_req,
    output logic                                fetch_req_ready,

    input  wire logic                           lsu_req_valid,
    input  wire mem_pkg::mem_req_t              lsu_req,
    output logic                                lsu_req_ready,

    output logic                                fetch_rsp_valid,
    output logic                                lsu_rsp_valid,
    output mem_pkg::mem_rsp_t                   rsp,

    input  wire logic                           oob_wen,
    input  wire logic [$clog2(`MEM_WORDS)-1:0]  oob_wr_addr,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     oob_wr_data
);
    import mem_pkg::*;

    logic                       fetch_head_valid;
    mem_req_t                   fetch_head;
    logic                       fetch_pop;

    logic                       lsu_head_valid;
    mem_req_t                   lsu_head;
    logic                       lsu_pop;

    logic                       issue;
    mem_req_t                   issue_req;
    logic                       busy;
    logic                       ack;
    logic [`MEM_DATA_WIDTH-1:0] rd_data;

    client_port fetch_port_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (fetch_req_valid),
        .req        (fetch_req),
        .req_ready  (fetch_req_ready),
        .head_valid (fetch_head_valid),
        .head       (fetch_head),
        .pop        (fetch_pop)
    );

    client_port lsu_port_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (lsu_req_valid),
        .req        (lsu_req),
        .req_ready  (lsu_req_ready),
        .head_valid (lsu_head_valid),
        .head       (lsu_head),
        .pop        (lsu_pop)
    );

    mem_arbiter arbiter_i (
        .clk              (clk),
        .rst              (rst),
        .fetch_head_valid (fetch_head_valid),
        .fetch_head       (fetch_head),
        .fetch_pop        (fetch_pop),
        .lsu_head_valid   (lsu_head_valid),
        .lsu_head         (lsu_head),
        .lsu_pop          (lsu_pop),
        .issue            (issue),
        .issue_req        (issue_req),
        .busy             (busy),
        .ack              (ack),
        .rd_data          (rd_data),
        .fetch_rsp_valid  (fetch_rsp_valid),
        .lsu_rsp_valid    (lsu_rsp_valid),
        .rsp              (rsp)
    );

    mem_delayed memory_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_req   (issue_req),
        .busy        (busy),
        .ack         (ack),
        .rd_data     (rd_data),
        .oob_wen     (oob_wen),
        .oob_wr_addr (oob_wr_addr),
        .oob_wr_data (oob_wr_data)
    );

endmodule

`default_nettype wire

/* tb/mem_subsystem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsystem_tb;
    import mem_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int IDX_W      = $clog2(`MEM_WORDS);
    localparam int DEPTH      = `MEM_QUEUE_DEPTH;
    localparam int EXP_SLOTS  = 128;
    localparam int TOTAL_REQS = 45;     // Sum over all six tests.
    localparam int WATCHDOG_CYCLES =
        `MEM_WORDS + 3 + TOTAL_REQS * (2 * `MEM_DELAY + 4) + 200;

    logic                       clk;
    logic                       rst;
    logic                       fetch_req_valid;
    mem_req_t                   fetch_req;
    logic                       fetch_req_ready;
    logic                       lsu_req_valid;
    mem_req_t                   lsu_req;
    logic                       lsu_req_ready;
    logic                       fetch_rsp_valid;
    logic                       lsu_rsp_valid;
    mem_rsp_t                   rsp;
    logic                       oob_wen;
    logic [IDX_W-1:0]           oob_wr_addr;
    logic [`MEM_DATA_WIDTH-1:0] oob_wr_data;

    logic [`MEM_DATA_WIDTH-1:0] ref_mem [`MEM_WORDS];   // Reference memory.
    mem_rsp_t   fetch_exp [EXP_SLOTS];
    mem_rsp_t   lsu_exp [EXP_SLOTS];
    int         fetch_wr = 0;
    int         lsu_wr = 0;
    int         fetch_rd = 0;   // Responses seen.
    int         lsu_rd = 0;
    int         fetch_acc = 0;  // Handshakes seen.
    int         lsu_acc = 0;
    logic       next_known = 1'b0;
    client_id_t next_owner = CLIENT_FETCH;
    int         cycle = 0;
    logic       latency_on = 1'b0;
    int         fetch_due = 0;
    int         fetch_stalls = 0;
    int         errors = 0;
    int         errors_at_start = 0;
    int         test_num = 1;
    int         failed_tests = 0;

    mem_subsystem dut_i (
        .clk             (clk),
        .rst             (rst),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .lsu_req_valid   (lsu_req_valid),
        .lsu_req         (lsu_req),
        .lsu_req_ready   (lsu_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .lsu_rsp_valid   (lsu_rsp_valid),
        .rsp             (rsp),
        .oob_wen         (oob_wen),
        .oob_wr_addr     (oob_wr_addr),
        .oob_wr_data     (oob_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Bookkeeping of handshakes and responses.
    always @(posedge clk) begin
        int fetch_waiting;
        int lsu_waiting;
        fetch_waiting = fetch_acc - fetch_rd + ((fetch_req_valid && fetch_req_ready) ? 1 : 0);
        lsu_waiting   = lsu_acc - lsu_rd + ((lsu_req_valid && lsu_req_ready) ? 1 : 0);
        if (fetch_req_valid && fetch_req_ready) fetch_acc <= fetch_acc + 1;
        if (lsu_req_valid && lsu_req_ready) lsu_acc <= lsu_acc + 1;
        if (fetch_rsp_valid) begin
            fetch_rd   <= fetch_rd + 1;
            next_known <= (lsu_waiting > 0);   // Waiting LSU entry wins next.
            next_owner <= CLIENT_LSU;
        end
        if (lsu_rsp_valid) begin
            lsu_rd     <= lsu_rd + 1;
            next_known <= (fetch_waiting > 0);
            next_owner <= CLIENT_FETCH;
        end
    end

    a_fetch_rsp: assert property (@(posedge clk) disable iff (rst)
        fetch_rsp_valid |-> (fetch_rd < fetch_wr) && (rsp == fetch_exp[fetch_rd]))
        else begin
            $display("MISMATCH at %0t ns: fetch response %h, expected %h",
                     $time, rsp, fetch_exp[fetch_rd]);
            errors++;
        end

    a_lsu_rsp: assert property (@(posedge clk) disable iff (rst)
        lsu_rsp_valid |-> (lsu_rd < lsu_wr) && (rsp == lsu_exp[lsu_rd]))
        else begin
            $display("MISMATCH at %0t ns: lsu response %h, expected %h",
                     $time, rsp, lsu_exp[lsu_rd]);
            errors++;
        end

    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        !(fetch_rsp_valid && lsu_rsp_valid))
        else begin
            $display("ERROR at %0t ns: both clients got a response in one cycle", $time);
            errors++;
        end

    a_alternate: assert property (@(posedge clk) disable iff (rst)
        (fetch_rsp_valid || lsu_rsp_valid) && next_known
            |-> (lsu_rsp_valid == (next_owner == CLIENT_LSU)))
        else begin
            $display("MISMATCH at %0t ns: response went to the client served last", $time);
            errors++;
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        latency_on |-> (fetch_rsp_valid == (cycle == fetch_due)))
        else begin
            $display("MISMATCH at %0t ns: fetch response timing in cycle %0d, due in %0d",
                     $time, cycle, fetch_due);
            errors++;
        end

    a_fetch_full: assert property (@(posedge clk) disable iff (rst)
        (fetch_acc - fetch_rd > DEPTH) |-> !fetch_req_ready)
        else begin
            $display("ERROR at %0t ns: fetch req_ready stayed high with a full queue", $time);
            errors++;
        end

    a_fetch_room: assert property (@(posedge clk) disable iff (rst)
        !fetch_req_ready |-> (fetch_acc - fetch_rd >= DEPTH))
        else begin
            $display("ERROR at %0t ns: fetch req_ready low with room in the queue", $time);
            errors++;
        end

    a_lsu_full: assert property (@(posedge clk) disable iff (rst)
        (lsu_acc - lsu_rd > DEPTH) |-> !lsu_req_ready)
        else begin
            $display("ERROR at %0t ns: lsu req_ready stayed high with a full queue", $time);
            errors++;
        end

    a_lsu_room: assert property (@(posedge clk) disable iff (rst)
        !lsu_req_ready |-> (lsu_acc - lsu_rd >= DEPTH))
        else begin
            $display("ERROR at %0t ns: lsu req_ready low with room in the queue", $time);
            errors++;
        end

    // Starts and ends on a falling edge, holds the request while not ready.
    task automatic send_req(input client_id_t who, input logic write,
                            input logic [`MEM_ADDR_WIDTH-1:0] addr,
                            input logic [`MEM_DATA_WIDTH-1:0] data);
        mem_req_t         req;
        mem_rsp_t         exp;
        logic [IDX_W-1:0] idx;
        req = '{write: write, addr: addr, data: data};
        idx = IDX_W'((addr >> 2) % `MEM_WORDS);
        if (who == CLIENT_FETCH) begin
            fetch_req_valid = 1'b1;
            fetch_req       = req;
            while (!fetch_req_ready) begin
                fetch_stalls++;
                @(negedge clk);
            end
        end else begin
            lsu_req_valid = 1'b1;
            lsu_req       = req;
            while (!lsu_req_ready) begin
                @(negedge clk);
            end
        end
        if (write) begin
            exp          = '{was_write: 1'b1, data: '0};
            ref_mem[idx] = data;
        end else begin
            exp = '{was_write: 1'b0, data: ref_mem[idx]};
        end
        if (who == CLIENT_FETCH) begin
            fetch_exp[fetch_wr] = exp;
            fetch_wr++;
        end else begin
            lsu_exp[lsu_wr] = exp;
            lsu_wr++;
        end
        @(negedge clk);     // Transfer on the edge in between.
        if (who == CLIENT_FETCH) fetch_req_valid = 1'b0;
        else lsu_req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while ((fetch_rd != fetch_wr) || (lsu_rd != lsu_wr)) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", test_num, name, errors - errors_at_start);
            failed_tests++;
        end
        test_num++;
        errors_at_start = errors;
        fetch_stalls    = 0;
    endtask

    initial begin
        int seed;
        seed            = 13;
        rst             = 1'b1;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        lsu_req_valid   = 1'b0;
        lsu_req         = '0;
        oob_wen         = 1'b0;
        oob_wr_addr     = '0;
        oob_wr_data     = '0;

        for (int i = 0; i < `MEM_WORDS; i++) begin
            @(negedge clk);
            oob_wen     = 1'b1;
            oob_wr_addr = IDX_W'(i);
            oob_wr_data = $random(seed);
            ref_mem[i]  = oob_wr_data;
        end
        @(negedge clk);
        oob_wen = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) send_req(CLIENT_FETCH, 1'b0, 32'(i * 4), '0);
        wait_drain();
        end_test("preload readback");

        for (int i = 0; i < 4; i++) send_req(CLIENT_LSU, 1'b1, 32'(64 + i * 4), $random(seed));
        for (int i = 0; i < 4; i++) send_req(CLIENT_LSU, 1'b0, 32'(64 + i * 4), '0);
        wait_drain();
        end_test("lsu write then read");

        fetch_due  = cycle + 2 + `MEM_DELAY;    // Pushed on the next rising edge.
        latency_on = 1'b1;
        send_req(CLIENT_FETCH, 1'b0, 32'h0000_00a0, '0);
        wait_drain();
        repeat (4) @(negedge clk);
        latency_on = 1'b0;
        end_test("idle read latency");

        fork
            begin
                for (int i = 0; i < 8; i++) send_req(CLIENT_FETCH, 1'b0, 32'(256 + i * 4), '0);
            end
            begin
                for (int j = 0; j < 4; j++) begin
                    send_req(CLIENT_LSU, 1'b1, 32'(384 + j * 4), $random(seed));
                    send_req(CLIENT_LSU, 1'b0, 32'(384 + j * 4), '0);
                end
            end
        join
        wait_drain();
        end_test("two-client alternation");

        for (int i = 0; i < 6; i++) send_req(CLIENT_FETCH, 1'b0, 32'(512 + i * 4), '0);
        assert (fetch_stalls > 0)
        else begin
            $display("ERROR at %0t ns: fetch req_ready never fell during a burst", $time);
            errors++;
        end
        wait_drain();
        end_test("fetch back-pressure");

        // Bits 1:0 and whole multiples of the memory size alias.
        send_req(CLIENT_LSU, 1'b1, 32'h0000_0320, $random(seed));
        send_req(CLIENT_LSU, 1'b0, 32'h0000_0323, '0);
        send_req(CLIENT_LSU, 1'b0, 32'h0000_0720, '0);
        send_req(CLIENT_LSU, 1'b0, 32'h8000_0320, '0);
        send_req(CLIENT_FETCH, 1'b0, 32'h0000_034a, '0);
        send_req(CLIENT_FETCH, 1'b0, 32'h0000_1748, '0);
        wait_drain();
        end_test("address aliasing");

        $display("summary: %0d tests, %0d failed, %0d errors", test_num - 1, failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/mem_pkg.sv
design/client_port.sv
design/mem_delayed.sv
design/mem_arbiter.sv
design/mem_subsystem.sv
tb/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsystem_tb -f sim.f -o sim_mem_subsystem \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_mem_subsystem)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED" && echo "run passed" || { echo "run failed"; exit 1; }
